// ==== exec_cluster.f ====
+incdir+common
common/exec_pkg.sv
common/issue_if.sv
regfile/regfile.sv
src/alu_unit.sv
src/mult_unit.sv
src/exec_cluster.sv
testbench/exec_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the exec_cluster testbench with Verilator, run it, and judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module exec_cluster_tb -f exec_cluster.f \
        -o exec_cluster_sim > build.log 2>&1 \
    && ./obj_dir/exec_cluster_sim 2>&1 | tee sim.log
grep -qsx "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== testbench/exec_cluster_tb.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module exec_cluster_tb import exec_pkg::*; ();

    // One expected broadcast with the cycle it is due on the CDB
    typedef struct packed {
        int        due;
        phys_tag_t tag;
        data_t     data;
    } expect_t;

    logic       clock;
    logic       reset;
    logic       alu_valid;
    logic       mult_valid;
    logic [2:0] alu_op;
    logic [2:0] mult_op;
    phys_tag_t  alu_src1, alu_src2, alu_dest;
    phys_tag_t  mult_src1, mult_src2, mult_dest;
    logic       cdb_alu_valid, cdb_mult_valid;
    phys_tag_t  cdb_alu_tag, cdb_mult_tag;
    data_t      cdb_alu_data, cdb_mult_data;

    // Lane values to drive at the next rising edge
    logic       p_reset;
    logic       p_alu_valid, p_mult_valid;
    logic [2:0] p_alu_op, p_mult_op;
    phys_tag_t  p_alu_src1, p_alu_src2, p_alu_dest;
    phys_tag_t  p_mult_src1, p_mult_src2, p_mult_dest;

    // Reference model state
    data_t       model_regs [`PHYS_REG_SZ];
    expect_t     alu_q [$];
    expect_t     mult_q [$];
    logic [31:0] rng;
    int          cycle, errors, checks;
    int          tests, failed_tests, test_base;
    logic [31:0] r;
    phys_tag_t   d, dm;

    exec_cluster exec_cluster_i (
        .clock          (clock),
        .reset          (reset),
        .alu_valid      (alu_valid),
        .alu_op         (alu_op),
        .alu_src1       (alu_src1),
        .alu_src2       (alu_src2),
        .alu_dest       (alu_dest),
        .mult_valid     (mult_valid),
        .mult_op        (mult_op),
        .mult_src1      (mult_src1),
        .mult_src2      (mult_src2),
        .mult_dest      (mult_dest),
        .cdb_alu_valid  (cdb_alu_valid),
        .cdb_alu_tag    (cdb_alu_tag),
        .cdb_alu_data   (cdb_alu_data),
        .cdb_mult_valid (cdb_mult_valid),
        .cdb_mult_tag   (cdb_mult_tag),
        .cdb_mult_data  (cdb_mult_data)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic data_t alu_ref(input logic [2:0] op, input data_t a, input data_t b);
        case (alu_op_e'(op))
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic data_t mult_ref(input logic hi, input data_t a, input data_t b);
        logic [63:0] product;
        product = 64'(a) * 64'(b);
        return hi ? product[63:32] : product[31:0];
    endfunction

    // Values due on the CDB this cycle bypass the array
    // The ALU slot is checked first
    function data_t read_operand(input phys_tag_t tag);
        if (alu_q.size() != 0 && alu_q[0].due == cycle && alu_q[0].tag == tag) begin
            return alu_q[0].data;
        end
        if (mult_q.size() != 0 && mult_q[0].due == cycle && mult_q[0].tag == tag) begin
            return mult_q[0].data;
        end
        return (tag == '0) ? '0 : model_regs[tag];
    endfunction

    task automatic check_slot(input string lane, input logic due, input expect_t e,
                              input logic valid, input phys_tag_t tag, input data_t data);
        checks++;
        if (due && valid !== 1'b1) begin
            errors++;
            $display("cycle %0d: %s result for tag %0d did not appear on the CDB",
                     cycle, lane, e.tag);
        end else if (!due && valid !== 1'b0) begin
            errors++;
            $display("cycle %0d: unexpected valid on the %s CDB slot", cycle, lane);
        end else if (due) begin
            if (tag !== e.tag) begin
                errors++;
                $display("mismatch cdb_%s_tag: expected %h, got %h (cycle %0d)",
                         lane, e.tag, tag, cycle);
            end
            if (data !== e.data) begin
                errors++;
                $display("mismatch cdb_%s_data: expected %h, got %h (cycle %0d)",
                         lane, e.data, data, cycle);
            end
        end
    endtask

    // Runs at the falling edge once the DUT outputs have settled
    task automatic model_cycle();
        logic    alu_due;
        logic    mult_due;
        expect_t a_e;
        expect_t m_e;
        expect_t n;
        a_e = '0;
        m_e = '0;
        alu_due = alu_q.size() != 0 && alu_q[0].due == cycle;
        mult_due = mult_q.size() != 0 && mult_q[0].due == cycle;
        if (alu_due) a_e = alu_q[0];
        if (mult_due) m_e = mult_q[0];
        if (reset) begin
            alu_q.delete();
            mult_q.delete();
            for (int i = 0; i < `PHYS_REG_SZ; i++) model_regs[i] = '0;
        end else begin
            check_slot("alu", alu_due, a_e, cdb_alu_valid, cdb_alu_tag, cdb_alu_data);
            check_slot("mult", mult_due, m_e, cdb_mult_valid, cdb_mult_tag, cdb_mult_data);
            if (alu_valid) begin
                n.due  = cycle + 1;
                n.tag  = alu_dest;
                n.data = alu_ref(alu_op, read_operand(alu_src1), read_operand(alu_src2));
                alu_q.push_back(n);
            end
            if (mult_valid) begin
                n.due  = cycle + `MULT_STAGES;
                n.tag  = mult_dest;
                n.data = mult_ref(mult_op[0], read_operand(mult_src1), read_operand(mult_src2));
                mult_q.push_back(n);
            end
            // Commit in slot order so the multiplier slot lands last
            if (alu_due) begin
                model_regs[a_e.tag] = a_e.data;
                void'(alu_q.pop_front());
            end
            if (mult_due) begin
                model_regs[m_e.tag] = m_e.data;
                void'(mult_q.pop_front());
            end
        end
    endtask

    task automatic step();
        @(posedge clock);
        reset      <= p_reset;
        alu_valid  <= p_alu_valid;
        alu_op     <= p_alu_op;
        alu_src1   <= p_alu_src1;
        alu_src2   <= p_alu_src2;
        alu_dest   <= p_alu_dest;
        mult_valid <= p_mult_valid;
        mult_op    <= p_mult_op;
        mult_src1  <= p_mult_src1;
        mult_src2  <= p_mult_src2;
        mult_dest  <= p_mult_dest;
        p_alu_valid  = 1'b0;
        p_mult_valid = 1'b0;
        @(negedge clock);
        cycle++;
        model_cycle();
    endtask

    task automatic issue_alu(input logic [2:0] op, input phys_tag_t s1, input phys_tag_t s2,
                             input phys_tag_t dest);
        p_alu_valid = 1'b1;
        p_alu_op    = op;
        p_alu_src1  = s1;
        p_alu_src2  = s2;
        p_alu_dest  = dest;
    endtask

    task automatic issue_mult(input logic [2:0] op, input phys_tag_t s1, input phys_tag_t s2,
                              input phys_tag_t dest);
        p_mult_valid = 1'b1;
        p_mult_op    = op;
        p_mult_src1  = s1;
        p_mult_src2  = s2;
        p_mult_dest  = dest;
    endtask

    task automatic rand_alu();
        logic [31:0] x;
        x = rand_word();
        issue_alu(x[2:0], x[8:3], x[14:9], {1'b0, x[19:15]});
    endtask

    // The unit only looks at opcode bit 0
    task automatic rand_mult();
        logic [31:0] x;
        x = rand_word();
        issue_mult(x[2:0], x[8:3], x[14:9], (x[23:20] == 4'd0) ? 6'd0 : {1'b1, x[19:15]});
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((alu_q.size() != 0 || mult_q.size() != 0) && waited < 20) begin
            step();
            waited++;
        end
        if (alu_q.size() != 0 || mult_q.size() != 0) begin
            errors++;
            $display("timeout: results still outstanding after %0d idle cycles", waited);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != test_base) begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - test_base);
        end else begin
            $display("test %s: pass", name);
        end
        test_base = errors;
    endtask

    initial begin
        rng = 32'hc46a60d4;
        {cycle, errors, checks, tests, failed_tests, test_base} = '0;
        reset = 1'b1;
        {alu_valid, alu_op, alu_src1, alu_src2, alu_dest} = '0;
        {mult_valid, mult_op, mult_src1, mult_src2, mult_dest} = '0;
        p_reset = 1'b1;
        {p_alu_valid, p_alu_op, p_alu_src1, p_alu_src2, p_alu_dest} = '0;
        {p_mult_valid, p_mult_op, p_mult_src1, p_mult_src2, p_mult_dest} = '0;
        step();
        step();
        p_reset = 1'b0;

        repeat (300) begin
            r = rand_word();
            if (r[1:0] != 2'd0) rand_alu();
            step();
        end
        drain();
        end_test("alu_random");

        repeat (120) begin
            rand_mult();
            step();
        end
        drain();
        end_test("mult_back_to_back");

        repeat (20) begin
            r  = rand_word();
            d  = {1'b0, r[4:0] | 5'd1};
            dm = {1'b1, r[9:5]};
            // ALU to ALU
            issue_alu(r[12:10], r[18:13], r[24:19], d);
            step();
            issue_alu(ALU_OR, d, 6'd0, d);
            step();
            // MULT to ALU with the consumer issued in the broadcast cycle
            issue_mult({2'b00, r[25]}, r[18:13], r[24:19], dm);
            step();
            step();
            step();
            issue_alu(ALU_ADD, dm, 6'd0, d);
            step();
            // ALU to MULT
            issue_alu(ALU_XOR, r[31:26], r[18:13], d);
            step();
            issue_mult({2'b00, r[26]}, d, d, dm);
            step();
        end
        drain();
        end_test("forwarding");

        repeat (10) begin
            r = rand_word();
            issue_alu(ALU_ADD, r[5:0] | 6'd32, r[5:0] | 6'd1, 6'd0);
            issue_mult({2'b00, r[6]}, r[12:7] | 6'd32, r[12:7] | 6'd1, 6'd0);
            repeat (4) step();
            issue_alu(ALU_OR, 6'd0, 6'd0, {1'b0, r[17:13]});
            issue_mult(3'd0, 6'd0, r[23:18], {1'b1, r[28:24]});
            step();
        end
        drain();
        end_test("zero_register");

        // Results still in flight when reset arrives must be dropped
        rand_mult();
        rand_alu();
        step();
        p_reset = 1'b1;
        step();
        step();
        p_reset = 1'b0;
        for (int t = 0; t < `PHYS_REG_SZ; t++) begin
            issue_alu(ALU_OR, 6'(t), 6'd0, 6'd0);
            step();
        end
        drain();
        end_test("mid_run_reset");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src/exec_cluster.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module exec_cluster import exec_pkg::*; (
    input  logic       clock,
    input  logic       reset,

    // ALU issue lane
    input  logic       alu_valid,
    input  logic [2:0] alu_op,
    input  phys_tag_t  alu_src1,
    input  phys_tag_t  alu_src2,
    input  phys_tag_t  alu_dest,

    // Multiply issue lane
    input  logic       mult_valid,
    input  logic [2:0] mult_op,
    input  phys_tag_t  mult_src1,
    input  phys_tag_t  mult_src2,
    input  phys_tag_t  mult_dest,

    // Broadcast results
    output logic       cdb_alu_valid,
    output phys_tag_t  cdb_alu_tag,
    output data_t      cdb_alu_data,
    output logic       cdb_mult_valid,
    output phys_tag_t  cdb_mult_tag,
    output data_t      cdb_mult_data
);

    issue_if alu_lane ();
    issue_if mult_lane ();

    prf_read_tags_t             read_tags;
    prf_read_data_t             read_data;
    cdb_entry_t                 alu_cdb;
    cdb_entry_t                 mult_cdb;
    cdb_entry_t [`CDB_SZ-1:0]   cdb_bus;

    assign alu_lane.valid  = alu_valid;
    assign alu_lane.op     = alu_op;
    assign alu_lane.src1   = alu_src1;
    assign alu_lane.src2   = alu_src2;
    assign alu_lane.dest   = alu_dest;

    assign mult_lane.valid = mult_valid;
    assign mult_lane.op    = mult_op;
    assign mult_lane.src1  = mult_src1;
    assign mult_lane.src2  = mult_src2;
    assign mult_lane.dest  = mult_dest;

    assign read_tags.alu[0]  = '{src1: alu_lane.src1, src2: alu_lane.src2};
    assign read_tags.mult[0] = '{src1: mult_lane.src1, src2: mult_lane.src2};

    regfile regfile_i (
        .clock      (clock),
        .reset      (reset),
        .read_tags  (read_tags),
        .read_data  (read_data),
        .cdb_writes (cdb_bus)
    );

    alu_unit alu_unit_i (
        .clock    (clock),
        .reset    (reset),
        .issue    (alu_lane),
        .operands (read_data.alu[0]),
        .cdb_out  (alu_cdb)
    );

    mult_unit mult_unit_i (
        .clock    (clock),
        .reset    (reset),
        .issue    (mult_lane),
        .operands (read_data.mult[0]),
        .cdb_out  (mult_cdb)
    );

    // Slot 0 is the ALU and slot 1 the multiplier
    assign cdb_bus[0] = alu_cdb;
    assign cdb_bus[1] = mult_cdb;

    assign cdb_alu_valid  = alu_cdb.valid;
    assign cdb_alu_tag    = alu_cdb.tag;
    assign cdb_alu_data   = alu_cdb.data;
    assign cdb_mult_valid = mult_cdb.valid;
    assign cdb_mult_tag   = mult_cdb.tag;
    assign cdb_mult_data  = mult_cdb.data;

endmodule

// ==== src/mult_unit.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module mult_unit import exec_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    issue_if.unit         issue,
    input  operand_pair_t operands,
    output cdb_entry_t    cdb_out
);

    // Stage 1 holds the issued operands
    logic      s1_valid;
    mult_op_e  s1_op;
    phys_tag_t s1_dest;
    data_t     s1_a;
    data_t     s1_b;

    // Stage 2 holds the full product
    logic                  s2_valid;
    mult_op_e              s2_op;
    phys_tag_t             s2_dest;
    logic [2*`DATA_W-1:0]  s2_prod;

    // Stage 3 drives the broadcast slot
    logic      s3_valid;
    phys_tag_t s3_dest;
    data_t     s3_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clock) begin
        // Only the low opcode bit selects the half
        s1_op   <= mult_op_e'(issue.op[0]);
        s1_dest <= issue.dest;
        s1_a    <= operands.op1;
        s1_b    <= operands.op2;

        s2_op   <= s1_op;
        s2_dest <= s1_dest;
        s2_prod <= {{`DATA_W{1'b0}}, s1_a} * {{`DATA_W{1'b0}}, s1_b};

        s3_dest <= s2_dest;
        s3_data <= (s2_op == MULT_HU) ? s2_prod[2*`DATA_W-1:`DATA_W] : s2_prod[`DATA_W-1:0];
    end

    assign cdb_out = '{valid: s3_valid, tag: s3_dest, data: s3_data};

    a_pipe_latency: assert property (@(posedge clock) disable iff (reset)
        s1_valid |-> ##(`MULT_STAGES-1) cdb_out.valid);

endmodule

// ==== src/alu_unit.sv ====
`timescale 1ns/100ps

module alu_unit import exec_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    issue_if.unit         issue,
    input  operand_pair_t operands,
    output cdb_entry_t    cdb_out
);

    alu_op_e   op;
    data_t     result;
    logic      valid_q;
    phys_tag_t tag_q;
    data_t     data_q;

    assign op = alu_op_e'(issue.op);

    always_comb begin
        case (op)
            ALU_ADD: result = operands.op1 + operands.op2;
            ALU_SUB: result = operands.op1 - operands.op2;
            ALU_AND: result = operands.op1 & operands.op2;
            ALU_OR:  result = operands.op1 | operands.op2;
            ALU_XOR: result = operands.op1 ^ operands.op2;
            // Shift amount from the low five bits
            ALU_SLL: result = operands.op1 << operands.op2[4:0];
            ALU_SRL: result = operands.op1 >> operands.op2[4:0];
            ALU_SLT: result = ($signed(operands.op1) < $signed(operands.op2)) ? data_t'(1) : '0;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue.valid;
        end
    end

    always_ff @(posedge clock) begin
        tag_q  <= issue.dest;
        data_q <= result;
    end

    // Result goes out on CDB slot 0 one cycle after issue
    assign cdb_out = '{valid: valid_q, tag: tag_q, data: data_q};

    a_idle_after_reset: assert property (@(posedge clock) reset |=> !cdb_out.valid);

endmodule

// ==== regfile/regfile.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module regfile import exec_pkg::*; (
    input  logic                         clock,
    input  logic                         reset,

    input  prf_read_tags_t               read_tags,
    output prf_read_data_t               read_data,

    input  cdb_entry_t [`CDB_SZ-1:0]     cdb_writes
);

    // Packed storage maps onto flops
    data_t [`PHYS_REG_SZ-1:0] regs;
    data_t [`PHYS_REG_SZ-1:0] regs_next;

    // Same-cycle bypass from the CDB, lowest slot first
    function automatic data_t read_fwd(phys_tag_t tag);
        data_t value;
        logic  hit;
        hit   = 1'b0;
        value = '0;
        for (int s = 0; s < `CDB_SZ; s++) begin
            if (!hit && cdb_writes[s].valid && cdb_writes[s].tag == tag) begin
                hit   = 1'b1;
                value = cdb_writes[s].data;
            end
        end
        if (!hit) begin
            value = (tag == '0) ? '0 : regs[tag];
        end
        return value;
    endfunction

    always_comb begin
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            read_data.alu[i].op1 = read_fwd(read_tags.alu[i].src1);
            read_data.alu[i].op2 = read_fwd(read_tags.alu[i].src2);
        end
        for (int i = 0; i < `NUM_FU_MULT; i++) begin
            read_data.mult[i].op1 = read_fwd(read_tags.mult[i].src1);
            read_data.mult[i].op2 = read_fwd(read_tags.mult[i].src2);
        end
    end

    // Later slots overwrite earlier ones
    always_comb begin
        regs_next = regs;
        for (int s = 0; s < `CDB_SZ; s++) begin
            if (cdb_writes[s].valid) begin
                regs_next[cdb_writes[s].tag] = cdb_writes[s].data;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '0;
        end else begin
            regs <= regs_next;
        end
    end

    // Issue rule keeps real destinations unique across the broadcast slots
    // Tag zero is a discard target and may repeat
    for (genvar a = 0; a < `CDB_SZ; a++) begin : g_slot_a
        for (genvar b = a + 1; b < `CDB_SZ; b++) begin : g_slot_b
            a_unique_tag: assert property (@(posedge clock) disable iff (reset)
                !(cdb_writes[a].valid && cdb_writes[b].valid &&
                  cdb_writes[a].tag == cdb_writes[b].tag &&
                  cdb_writes[a].tag != '0));
        end
    end

endmodule

// ==== common/issue_if.sv ====
`timescale 1ns/100ps

interface issue_if import exec_pkg::*; ();

    // Valid-only lane, every valid cycle is one accepted operation
    logic       valid;
    logic [2:0] op;
    phys_tag_t  src1;
    phys_tag_t  src2;
    phys_tag_t  dest;

    modport issuer (
        output valid, op, src1, src2, dest
    );

    modport unit (
        input valid, op, src1, src2, dest
    );

endinterface

// ==== common/exec_pkg.sv ====
`include "exec_params.svh"

package exec_pkg;

    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`TAG_W-1:0]  phys_tag_t;

    // One broadcast slot on the result bus
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        data_t     data;
    } cdb_entry_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // Both halves of the unsigned product
    typedef enum logic {
        MULT_LO = 1'b0,
        MULT_HU = 1'b1
    } mult_op_e;

    typedef struct packed {
        phys_tag_t src1;
        phys_tag_t src2;
    } read_pair_t;

    typedef struct packed {
        data_t op1;
        data_t op2;
    } operand_pair_t;

    // Reads grouped by unit type
    typedef struct packed {
        read_pair_t [`NUM_FU_ALU-1:0]  alu;
        read_pair_t [`NUM_FU_MULT-1:0] mult;
    } prf_read_tags_t;

    typedef struct packed {
        operand_pair_t [`NUM_FU_ALU-1:0]  alu;
        operand_pair_t [`NUM_FU_MULT-1:0] mult;
    } prf_read_data_t;

endpackage

// ==== common/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath widths
`define DATA_W      32
`define TAG_W       6

// Physical register file depth, tag 0 is the zero register
`define PHYS_REG_SZ 64

// Result broadcast slots
// Slot 0 carries ALU results and slot 1 multiplier results
`define CDB_SZ      2

// Lanes per functional unit group
`define NUM_FU_ALU  1
`define NUM_FU_MULT 1

// Multiplier latency from issue to broadcast
`define MULT_STAGES 3

`endif
